// ==== rtl/dcache_config.svh ====
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// cpu side widths
`define DC_ADDR_W 32
`define DC_WORD_W 32

// cache geometry, two ways of DC_NSET lines each
`define DC_LINE_BYTES 16
`define DC_NSET 256

// evicted dirty lines waiting for memory
`define DC_WB_DEPTH 2

// galois lfsr for victim choice, taps for x^16 + x^14 + x^13 + x^11 + 1
`define DC_LFSR_W 16
`define DC_LFSR_SEED 16'hACE1
`define DC_LFSR_TAPS 16'hB400

`endif

// ==== rtl/dcache_pkg.sv ====
`include "dcache_config.svh"

package dcache_pkg;

    // address split: tag | index | word offset | byte offset
    localparam int OFFSET_W = $clog2(`DC_LINE_BYTES);
    localparam int INDEX_W = $clog2(`DC_NSET);
    localparam int LINE_ADDR_W = `DC_ADDR_W - OFFSET_W;
    localparam int TAG_W = LINE_ADDR_W - INDEX_W;
    localparam int WORD_SEL_W = $clog2(`DC_LINE_BYTES * 8 / `DC_WORD_W);

    typedef logic [`DC_WORD_W-1:0] word_t;
    typedef logic [`DC_WORD_W/8-1:0] strb_t;
    typedef logic [`DC_LINE_BYTES*8-1:0] line_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;

    // one tag array entry, 22 bits
    typedef struct packed {
        logic dirty;
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL_REQ,
        REFILL_WAIT
    } ctrl_state_e;

endpackage

// ==== rtl/way_ram.sv ====
`timescale 1ns/1ps

module way_ram #(
    parameter type entry_t = logic,
    parameter int DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  logic                     we_i,
    input  entry_t                   wdata_i,
    output entry_t                   rdata_o,
    output logic                     busy_o
);

    localparam int AW = $clog2(DEPTH);

    entry_t mem [DEPTH];

    logic          sweeping;
    logic [AW-1:0] sweep_cnt;

    // clear sweep, one entry per cycle once reset is released
    always_ff @(posedge clk) begin
        if (rst) begin
            sweeping <= 1'b1;
            sweep_cnt <= '0;
        end else if (sweeping) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            if (sweep_cnt == AW'(DEPTH - 1)) begin
                sweeping <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sweeping && !rst) begin
            mem[sweep_cnt] <= '0;
        end else if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];
    end

    assign busy_o = sweeping;

    // the controller must stay in IDLE until every array is cleared
    a_no_write_in_sweep: assert property (@(posedge clk) disable iff (rst)
        busy_o |-> !we_i);

endmodule

// ==== rtl/store_merge.sv ====
`timescale 1ns/1ps

module store_merge (
    input  dcache_pkg::line_t                       line_i,
    input  logic [dcache_pkg::WORD_SEL_W-1:0]       offset_i,
    input  dcache_pkg::strb_t                       strb_i,
    input  dcache_pkg::word_t                       wdata_i,
    output dcache_pkg::line_t                       line_o,
    output dcache_pkg::word_t                       word_o
);

    localparam int WORD_W = $bits(dcache_pkg::word_t);
    localparam int NBYTE = $bits(dcache_pkg::strb_t);

    // addressed word of the incoming line, used by loads
    assign word_o = line_i[offset_i*WORD_W +: WORD_W];

    // strobed bytes replace the addressed word, all else passes through
    always_comb begin
        line_o = line_i;
        for (int b = 0; b < NBYTE; b++) begin
            if (strb_i[b]) begin
                line_o[offset_i*WORD_W + b*8 +: 8] = wdata_i[b*8 +: 8];
            end
        end
    end

endmodule

// ==== rtl/writeback_buffer.sv ====
`timescale 1ns/1ps

module writeback_buffer #(
    parameter int DEPTH = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push_i,
    input  dcache_pkg::line_addr_t push_addr_i,
    input  dcache_pkg::line_t      push_line_i,
    input  logic                   pop_i,
    input  dcache_pkg::line_addr_t lookup_addr_i,
    output logic                   valid_o,
    output logic                   full_o,
    output logic                   match_o,
    output dcache_pkg::line_addr_t head_addr_o,
    output dcache_pkg::line_t      head_line_o
);

    // DEPTH is a power of two so the pointers wrap on their own
    localparam int PTR_W = $clog2(DEPTH);

    dcache_pkg::line_addr_t addr_q [DEPTH];
    dcache_pkg::line_t      line_q [DEPTH];

    logic [DEPTH-1:0] used_q;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [DEPTH-1:0] hit_vec;

    always_ff @(posedge clk) begin
        if (rst) begin
            used_q <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_i) begin
                used_q[wr_ptr] <= 1'b1;
                wr_ptr <= wr_ptr + 1'b1;
            end
            // push and pop never hit the same slot, the buffer is neither full nor empty then
            if (pop_i) begin
                used_q[rd_ptr] <= 1'b0;
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            addr_q[wr_ptr] <= push_addr_i;
            line_q[wr_ptr] <= push_line_i;
        end
    end

    // every live entry is checked against the line about to be fetched
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            hit_vec[i] = used_q[i] && (addr_q[i] == lookup_addr_i);
        end
    end

    assign match_o = |hit_vec;
    assign valid_o = |used_q;
    assign full_o = &used_q;
    assign head_addr_o = addr_q[rd_ptr];
    assign head_line_o = line_q[rd_ptr];

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop_i |-> valid_o);

endmodule

// ==== rtl/dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    busy_i,
    // cpu request
    input  logic                                    req_valid_i,
    input  logic [`DC_ADDR_W-1:0]                   req_addr_i,
    input  dcache_pkg::strb_t                       req_wstrb_i,
    input  dcache_pkg::word_t                       req_wdata_i,
    output logic                                    data_ok_o,
    output dcache_pkg::word_t                       rdata_o,
    // memory port
    input  logic                                    mem_ready_i,
    input  logic                                    mem_rvalid_i,
    input  dcache_pkg::line_t                       mem_rdata_i,
    output logic                                    mem_req_o,
    output logic                                    mem_we_o,
    output dcache_pkg::line_addr_t                  mem_addr_o,
    output dcache_pkg::line_t                       mem_wdata_o,
    // tag and data arrays
    input  dcache_pkg::tag_entry_t [1:0]            tag_rdata_i,
    input  dcache_pkg::line_t [1:0]                 line_rdata_i,
    output dcache_pkg::index_t                      ram_addr_o,
    output logic [1:0]                              tag_we_o,
    output logic [1:0]                              line_we_o,
    output dcache_pkg::tag_entry_t                  tag_wdata_o,
    output dcache_pkg::line_t                       line_wdata_o,
    // store merge unit
    input  dcache_pkg::line_t                       merged_line_i,
    input  dcache_pkg::word_t                       sel_word_i,
    output dcache_pkg::line_t                       merge_line_o,
    output logic [dcache_pkg::WORD_SEL_W-1:0]       merge_offset_o,
    output dcache_pkg::strb_t                       merge_strb_o,
    output dcache_pkg::word_t                       merge_wdata_o,
    // write-back buffer
    input  logic                                    wb_full_i,
    input  logic                                    wb_valid_i,
    input  logic                                    wb_match_i,
    input  dcache_pkg::line_addr_t                  wb_head_addr_i,
    input  dcache_pkg::line_t                       wb_head_line_i,
    output logic                                    wb_push_o,
    output dcache_pkg::line_addr_t                  wb_push_addr_o,
    output dcache_pkg::line_t                       wb_push_line_o,
    output dcache_pkg::line_addr_t                  wb_lookup_addr_o,
    output logic                                    wb_pop_o
);

    localparam int OFS_W = dcache_pkg::OFFSET_W;
    localparam int IDX_W = dcache_pkg::INDEX_W;
    localparam int SEL_W = dcache_pkg::WORD_SEL_W;

    dcache_pkg::ctrl_state_e state_q, state_d;

    logic [`DC_LFSR_W-1:0]  lfsr_q;
    logic [`DC_ADDR_W-1:0]  req_addr_q;
    dcache_pkg::strb_t      req_wstrb_q;
    dcache_pkg::word_t      req_wdata_q;
    logic                   victim_way_q;
    dcache_pkg::tag_entry_t victim_entry_q;
    dcache_pkg::line_t      victim_line_q;

    dcache_pkg::line_addr_t req_line;
    dcache_pkg::index_t     req_index;
    dcache_pkg::tag_t       req_tag;
    logic                   is_store;
    logic [1:0]             hit_vec;
    logic                   hit;
    logic                   hit_way;
    logic                   refill_blocked;
    logic                   drain;

    assign req_line = req_addr_q[`DC_ADDR_W-1:OFS_W];
    assign req_index = req_line[IDX_W-1:0];
    assign req_tag = req_line[$bits(dcache_pkg::line_addr_t)-1:IDX_W];
    assign is_store = |req_wstrb_q;

    // tag compare on the array outputs of the LOOKUP cycle
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_vec[w] = tag_rdata_i[w].valid && (tag_rdata_i[w].tag == req_tag);
        end
    end
    assign hit = |hit_vec;
    assign hit_way = hit_vec[1];

    // the refill waits until no older copy of the line sits in the buffer
    assign refill_blocked = wb_full_i || wb_match_i;

    assign merge_offset_o = req_addr_q[OFS_W-1 -: SEL_W];
    assign merge_strb_o = req_wstrb_q;
    assign merge_wdata_o = req_wdata_q;
    assign rdata_o = sel_word_i;
    assign mem_wdata_o = wb_head_line_i;
    assign wb_lookup_addr_o = req_line;
    assign wb_push_addr_o = {victim_entry_q.tag, req_index};
    assign wb_push_line_o = victim_line_q;
    // a zero strobe leaves the line untouched, so loads write back the plain line
    assign line_wdata_o = merged_line_i;

    always_comb begin
        state_d = state_q;
        ram_addr_o = req_index;
        tag_we_o = '0;
        line_we_o = '0;
        tag_wdata_o = '{dirty: is_store, valid: 1'b1, tag: req_tag};
        merge_line_o = line_rdata_i[hit_way];
        wb_push_o = 1'b0;
        wb_pop_o = 1'b0;
        mem_req_o = 1'b0;
        mem_we_o = 1'b0;
        mem_addr_o = wb_head_addr_i;
        data_ok_o = 1'b0;
        drain = 1'b0;
        case (state_q)
            dcache_pkg::IDLE: begin
                drain = 1'b1;
                if (req_valid_i && !busy_i) begin
                    ram_addr_o = req_addr_i[OFS_W +: IDX_W];
                    state_d = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                drain = 1'b1;
                if (hit) begin
                    data_ok_o = 1'b1;
                    tag_we_o[hit_way] = is_store;
                    line_we_o[hit_way] = is_store;
                    state_d = dcache_pkg::IDLE;
                end else begin
                    state_d = dcache_pkg::REFILL_REQ;
                end
            end
            dcache_pkg::REFILL_REQ: begin
                if (refill_blocked) begin
                    drain = 1'b1;
                end else begin
                    mem_req_o = 1'b1;
                    mem_addr_o = req_line;
                    if (mem_ready_i) begin
                        state_d = dcache_pkg::REFILL_WAIT;
                    end
                end
            end
            dcache_pkg::REFILL_WAIT: begin
                merge_line_o = mem_rdata_i;
                if (mem_rvalid_i) begin
                    tag_we_o[victim_way_q] = 1'b1;
                    line_we_o[victim_way_q] = 1'b1;
                    wb_push_o = victim_entry_q.valid && victim_entry_q.dirty;
                    data_ok_o = 1'b1;
                    state_d = dcache_pkg::IDLE;
                end
            end
            default: begin
                state_d = dcache_pkg::IDLE;
            end
        endcase
        // buffer head goes out whenever the port is free for it
        if (drain && wb_valid_i) begin
            mem_req_o = 1'b1;
            mem_we_o = 1'b1;
            wb_pop_o = mem_ready_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= dcache_pkg::IDLE;
            lfsr_q <= `DC_LFSR_SEED;
        end else begin
            state_q <= state_d;
            lfsr_q <= lfsr_q[0] ? ((lfsr_q >> 1) ^ `DC_LFSR_TAPS) : (lfsr_q >> 1);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == dcache_pkg::IDLE && state_d == dcache_pkg::LOOKUP) begin
            req_addr_q <= req_addr_i;
            req_wstrb_q <= req_wstrb_i;
            req_wdata_q <= req_wdata_i;
        end
        // victim is picked by one lfsr bit and kept until the refill returns
        if (state_q == dcache_pkg::LOOKUP && !hit) begin
            victim_way_q <= lfsr_q[0];
            victim_entry_q <= tag_rdata_i[lfsr_q[0]];
            victim_line_q <= line_rdata_i[lfsr_q[0]];
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        wb_push_o |-> !wb_full_i);

    // one read outstanding, the port stays quiet until the line arrives
    a_quiet_refill_wait: assert property (@(posedge clk) disable iff (rst)
        (mem_req_o && mem_ready_i && !mem_we_o) |=> (!mem_req_o until_with mem_rvalid_i));

endmodule

// ==== rtl/dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid_i,
    input  logic [`DC_ADDR_W-1:0]  req_addr_i,
    input  dcache_pkg::strb_t      req_wstrb_i,
    input  dcache_pkg::word_t      req_wdata_i,
    output logic                   data_ok_o,
    output dcache_pkg::word_t      rdata_o,
    input  logic                   mem_ready_i,
    input  logic                   mem_rvalid_i,
    input  dcache_pkg::line_t      mem_rdata_i,
    output logic                   mem_req_o,
    output logic                   mem_we_o,
    output dcache_pkg::line_addr_t mem_addr_o,
    output dcache_pkg::line_t      mem_wdata_o
);

    dcache_pkg::index_t               ram_addr;
    logic [1:0]                       tag_we;
    logic [1:0]                       line_we;
    logic [1:0]                       tag_busy;
    logic [1:0]                       line_busy;
    dcache_pkg::tag_entry_t           tag_wdata;
    dcache_pkg::line_t                line_wdata;
    dcache_pkg::tag_entry_t [1:0]     tag_rdata;
    dcache_pkg::line_t [1:0]          line_rdata;

    dcache_pkg::line_t                merge_line;
    logic [dcache_pkg::WORD_SEL_W-1:0] merge_offset;
    dcache_pkg::strb_t                merge_strb;
    dcache_pkg::word_t                merge_wdata;
    dcache_pkg::line_t                merged_line;
    dcache_pkg::word_t                sel_word;

    logic                             wb_push;
    logic                             wb_pop;
    logic                             wb_valid;
    logic                             wb_full;
    logic                             wb_match;
    dcache_pkg::line_addr_t           wb_push_addr;
    dcache_pkg::line_addr_t           wb_lookup_addr;
    dcache_pkg::line_addr_t           wb_head_addr;
    dcache_pkg::line_t                wb_push_line;
    dcache_pkg::line_t                wb_head_line;

    dcache_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .busy_i           (|{tag_busy, line_busy}),
        .req_valid_i      (req_valid_i),
        .req_addr_i       (req_addr_i),
        .req_wstrb_i      (req_wstrb_i),
        .req_wdata_i      (req_wdata_i),
        .data_ok_o        (data_ok_o),
        .rdata_o          (rdata_o),
        .mem_ready_i      (mem_ready_i),
        .mem_rvalid_i     (mem_rvalid_i),
        .mem_rdata_i      (mem_rdata_i),
        .mem_req_o        (mem_req_o),
        .mem_we_o         (mem_we_o),
        .mem_addr_o       (mem_addr_o),
        .mem_wdata_o      (mem_wdata_o),
        .tag_rdata_i      (tag_rdata),
        .line_rdata_i     (line_rdata),
        .ram_addr_o       (ram_addr),
        .tag_we_o         (tag_we),
        .line_we_o        (line_we),
        .tag_wdata_o      (tag_wdata),
        .line_wdata_o     (line_wdata),
        .merged_line_i    (merged_line),
        .sel_word_i       (sel_word),
        .merge_line_o     (merge_line),
        .merge_offset_o   (merge_offset),
        .merge_strb_o     (merge_strb),
        .merge_wdata_o    (merge_wdata),
        .wb_full_i        (wb_full),
        .wb_valid_i       (wb_valid),
        .wb_match_i       (wb_match),
        .wb_head_addr_i   (wb_head_addr),
        .wb_head_line_i   (wb_head_line),
        .wb_push_o        (wb_push),
        .wb_push_addr_o   (wb_push_addr),
        .wb_push_line_o   (wb_push_line),
        .wb_lookup_addr_o (wb_lookup_addr),
        .wb_pop_o         (wb_pop)
    );

    // one tag array and one data array per way, all on the same set index
    for (genvar w = 0; w < 2; w++) begin : g_way
        way_ram #(
            .entry_t (dcache_pkg::tag_entry_t),
            .DEPTH   (`DC_NSET)
        ) u_tag_ram (
            .clk     (clk),
            .rst     (rst),
            .addr_i  (ram_addr),
            .we_i    (tag_we[w]),
            .wdata_i (tag_wdata),
            .rdata_o (tag_rdata[w]),
            .busy_o  (tag_busy[w])
        );

        way_ram #(
            .entry_t (dcache_pkg::line_t),
            .DEPTH   (`DC_NSET)
        ) u_line_ram (
            .clk     (clk),
            .rst     (rst),
            .addr_i  (ram_addr),
            .we_i    (line_we[w]),
            .wdata_i (line_wdata),
            .rdata_o (line_rdata[w]),
            .busy_o  (line_busy[w])
        );
    end

    store_merge u_merge (
        .line_i   (merge_line),
        .offset_i (merge_offset),
        .strb_i   (merge_strb),
        .wdata_i  (merge_wdata),
        .line_o   (merged_line),
        .word_o   (sel_word)
    );

    writeback_buffer #(
        .DEPTH (`DC_WB_DEPTH)
    ) u_wb_buf (
        .clk           (clk),
        .rst           (rst),
        .push_i        (wb_push),
        .push_addr_i   (wb_push_addr),
        .push_line_i   (wb_push_line),
        .pop_i         (wb_pop),
        .lookup_addr_i (wb_lookup_addr),
        .valid_o       (wb_valid),
        .full_o        (wb_full),
        .match_o       (wb_match),
        .head_addr_o   (wb_head_addr),
        .head_line_o   (wb_head_line)
    );

endmodule

// ==== testbench/mem_model.sv ====
`timescale 1ns/1ps

module mem_model #(
    parameter int READ_LAT = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ready_bit_i,
    input  logic                   mem_req_i,
    input  logic                   mem_we_i,
    input  dcache_pkg::line_addr_t mem_addr_i,
    input  dcache_pkg::line_t      mem_wdata_i,
    output logic                   mem_ready_o,
    output logic                   mem_rvalid_o,
    output dcache_pkg::line_t      mem_rdata_o,
    output int                     wr_count_o
);

    dcache_pkg::line_t      mem [dcache_pkg::line_addr_t];
    dcache_pkg::line_addr_t wr_log [$];

    logic                   take;
    logic                   take_we;
    dcache_pkg::line_addr_t take_addr;
    dcache_pkg::line_t      take_line;
    dcache_pkg::line_addr_t rd_addr;
    int                     rd_wait;

    // untouched words hold their own byte address xor a constant
    function automatic dcache_pkg::line_t read_line(input dcache_pkg::line_addr_t la);
        dcache_pkg::line_t l;
        if (mem.exists(la)) begin
            return mem[la];
        end
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = {la, 2'(w), 2'b00} ^ 32'hC3A5_5A3C;
        end
        return l;
    endfunction

    assign mem_ready_o = ready_bit_i;

    initial begin
        mem_rvalid_o = 1'b0;
        mem_rdata_o = '0;
        wr_count_o = 0;
        rd_wait = 0;
    end

    // handshake sampled mid cycle, response driven just after the edge
    always begin
        @(negedge clk);
        take = !rst && mem_req_i && mem_ready_o;
        take_we = mem_we_i;
        take_addr = mem_addr_i;
        take_line = mem_wdata_i;
        @(posedge clk);
        #2;
        mem_rvalid_o = 1'b0;
        if (rd_wait > 0) begin
            rd_wait--;
            if (rd_wait == 0) begin
                mem_rvalid_o = 1'b1;
                mem_rdata_o = read_line(rd_addr);
            end
        end
        if (take && take_we) begin
            mem[take_addr] = take_line;
            wr_log.push_back(take_addr);
            wr_count_o = wr_log.size();
        end else if (take) begin
            rd_addr = take_addr;
            rd_wait = READ_LAT;
        end
    end

endmodule

// ==== testbench/tb_dcache.sv ====
`timescale 1ns/1ps
`include "dcache_config.svh"

module tb_dcache;

    // one table row where a zero strobe means a load
    typedef struct packed {
        logic        expect_hit;
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [31:0] data;
    } stim_t;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   req_valid;
    logic [31:0]            req_addr;
    dcache_pkg::strb_t      req_wstrb;
    dcache_pkg::word_t      req_wdata;
    logic                   data_ok;
    dcache_pkg::word_t      rdata;
    logic                   mem_req;
    logic                   mem_we;
    dcache_pkg::line_addr_t mem_addr;
    dcache_pkg::line_t      mem_wdata;
    logic                   mem_ready;
    logic                   mem_rvalid;
    dcache_pkg::line_t      mem_rdata;
    int                     wr_count;

    stim_t                  stim_q [$];
    logic [31:0]            shadow [int unsigned];
    logic [15:0]            stim_lfsr;
    logic [15:0]            ready_lfsr = 16'd1625;
    int                     errors = 0;
    int                     checks = 0;
    int                     mem_reads = 0;
    int                     cycles = 0;
    int                     timeout_limit;
    int                     evict_first;
    int                     evict_last;
    int                     wr_before;
    dcache_pkg::ctrl_state_e st;

    dcache_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid),
        .req_addr_i   (req_addr),
        .req_wstrb_i  (req_wstrb),
        .req_wdata_i  (req_wdata),
        .data_ok_o    (data_ok),
        .rdata_o      (rdata),
        .mem_ready_i  (mem_ready),
        .mem_rvalid_i (mem_rvalid),
        .mem_rdata_i  (mem_rdata),
        .mem_req_o    (mem_req),
        .mem_we_o     (mem_we),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata)
    );

    mem_model u_mem (
        .clk          (clk),
        .rst          (rst),
        .ready_bit_i  (ready_lfsr[0]),
        .mem_req_i    (mem_req),
        .mem_we_i     (mem_we),
        .mem_addr_i   (mem_addr),
        .mem_wdata_i  (mem_wdata),
        .mem_ready_o  (mem_ready),
        .mem_rvalid_o (mem_rvalid),
        .mem_rdata_o  (mem_rdata),
        .wr_count_o   (wr_count)
    );

    always #20 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] shadow_read(input logic [31:0] addr);
        if (shadow.exists(addr >> 2)) begin
            return shadow[addr >> 2];
        end
        return {addr[31:2], 2'b00} ^ 32'hC3A5_5A3C;
    endfunction

    function automatic dcache_pkg::line_t shadow_line(input dcache_pkg::line_addr_t la);
        dcache_pkg::line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = shadow_read({la, 2'(w), 2'b00});
        end
        return l;
    endfunction

    task automatic shadow_store(input logic [31:0] addr, input logic [3:0] strb,
                                input logic [31:0] data);
        logic [31:0] w;
        w = shadow_read(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        shadow[addr >> 2] = w;
    endtask

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic add_stim(input logic hit, input logic [31:0] addr, input logic [3:0] strb,
                            input logic [31:0] data);
        stim_q.push_back('{expect_hit: hit, addr: addr, strb: strb, data: data});
    endtask

    task automatic build_table();
        logic [3:0] strb;
        logic [1:0] kind;
        logic [1:0] pos;
        logic [2:0] tag;
        logic [1:0] set;
        logic [1:0] word;
        logic       store;
        // load miss then a hit on the same line
        add_stim(1'b0, 32'h0000_1230, 4'b0000, 32'h0);
        add_stim(1'b1, 32'h0000_1234, 4'b0000, 32'h0);
        // byte, half and word stores that hit
        add_stim(1'b1, 32'h0000_1234, 4'b0010, 32'hAABB_CCDD);
        add_stim(1'b1, 32'h0000_1234, 4'b0000, 32'h0);
        add_stim(1'b1, 32'h0000_1238, 4'b1100, 32'h1122_3344);
        add_stim(1'b1, 32'h0000_1238, 4'b0000, 32'h0);
        add_stim(1'b1, 32'h0000_123C, 4'b1111, 32'hDEAD_BEEF);
        add_stim(1'b1, 32'h0000_123C, 4'b0000, 32'h0);
        // the same three widths as store misses
        add_stim(1'b0, 32'h0000_2A40, 4'b1000, 32'h9988_7766);
        add_stim(1'b1, 32'h0000_2A40, 4'b0000, 32'h0);
        add_stim(1'b0, 32'h0000_3B50, 4'b0011, 32'h5544_3322);
        add_stim(1'b1, 32'h0000_3B50, 4'b0000, 32'h0);
        add_stim(1'b0, 32'h0000_4C60, 4'b1111, 32'h0F1E_2D3C);
        add_stim(1'b1, 32'h0000_4C60, 4'b0000, 32'h0);
        // three lines of set 7 in a two way cache
        evict_first = stim_q.size();
        add_stim(1'b0, 32'h0010_0070, 4'b1111, 32'h1111_0001);
        add_stim(1'b0, 32'h0020_0074, 4'b1111, 32'h2222_0002);
        add_stim(1'b0, 32'h0030_0078, 4'b1111, 32'h3333_0003);
        add_stim(1'b0, 32'h0010_0070, 4'b0000, 32'h0);
        add_stim(1'b0, 32'h0020_0074, 4'b0000, 32'h0);
        add_stim(1'b0, 32'h0030_0078, 4'b0000, 32'h0);
        evict_last = stim_q.size() - 1;
        // eight tags over four sets keep the buffer busy
        for (int i = 0; i < 200; i++) begin
            store = 1'(rand_bits(1));
            kind = 2'(rand_bits(2));
            pos = 2'(rand_bits(2));
            tag = 3'(rand_bits(3));
            set = 2'(rand_bits(2));
            word = 2'(rand_bits(2));
            if (!store) begin
                strb = 4'b0000;
            end else if (kind == 2'd0) begin
                strb = 4'b0001 << pos;
            end else if (kind == 2'd1) begin
                strb = pos[1] ? 4'b1100 : 4'b0011;
            end else begin
                strb = 4'b1111;
            end
            add_stim(1'b0, {20'h00080 + 20'(tag), 6'h10, set, word, 2'b00}, strb,
                     rand_bits(32));
        end
    endtask

    task automatic do_request(input stim_t s);
        logic [31:0] exp_word;
        int          lat;
        int          reads_before;
        exp_word = shadow_read(s.addr);
        @(posedge clk);
        #2;
        req_valid = 1'b1;
        req_addr = s.addr;
        req_wstrb = s.strb;
        req_wdata = s.data;
        reads_before = mem_reads;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (data_ok !== 1'b1);
        if (s.strb == 4'b0000) begin
            check_value("rdata_o", exp_word, rdata);
        end else begin
            shadow_store(s.addr, s.strb, s.data);
        end
        if (s.expect_hit) begin
            check_value("hit latency", 1, lat);
            // reads of the answer cycle are counted at its negedge
            @(posedge clk);
            check_value("memory reads on hit", reads_before, mem_reads);
        end
    endtask

    always @(posedge clk) begin
        #2;
        ready_lfsr = lfsr_step(ready_lfsr);
    end

    // every line written back must match the shadow copy of that line
    always @(negedge clk) begin
        if (!rst && mem_req && mem_ready) begin
            if (mem_we) begin
                check_value("mem_wdata_o", shadow_line(mem_addr), mem_wdata);
            end else begin
                mem_reads++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_limit) begin
            st = dut_i.u_ctrl.state_q;
            $display("run timed out after %0d cycles with the controller in %s", cycles,
                     st.name());
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_wstrb = '0;
        req_wdata = '0;
        stim_lfsr = 16'd1625;
        build_table();
        timeout_limit = stim_q.size() * 40 + `DC_NSET + 40;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        // nothing leaves the cache while the arrays are cleared
        repeat (`DC_NSET + 4) begin
            @(negedge clk);
            check_value("data_ok_o", 0, data_ok);
            check_value("mem_req_o", 0, mem_req);
        end
        for (int i = 0; i < stim_q.size(); i++) begin
            if (i == evict_first) begin
                wr_before = wr_count;
            end
            do_request(stim_q[i]);
            if (i == evict_last) begin
                while (wr_count == wr_before) begin
                    @(negedge clk);
                end
            end
        end
        $display("checks %0d, errors %0d, memory reads %0d, memory writes %0d", checks, errors,
                 mem_reads, wr_count);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/dcache_pkg.sv
rtl/way_ram.sv
rtl/store_merge.sv
rtl/writeback_buffer.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
testbench/mem_model.sv
testbench/tb_dcache.sv
